// File: design/exp_sum_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exp_sum_unit (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire gat_pkg::coef_t coef,
  input  wire logic          accept,
  input  wire logic          first,
  output gat_pkg::exp_t      exp,
  output gat_pkg::sum_t      sum_next
);

  gat_pkg::sum_t sum_q;

  // 2^c, always nonzero
  assign exp = gat_pkg::exp_t'(1) << coef;

  // restart on the first node of a subgraph
  assign sum_next = first ? gat_pkg::sum_t'(exp) : sum_q + gat_pkg::sum_t'(exp);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (accept) begin
      sum_q <= sum_next;
    end
  end

endmodule

`default_nettype wire

// File: design/fxp_divider.sv
`timescale 1ns/100ps
`default_nettype none

module fxp_divider (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           issue,
  input  wire gat_pkg::exp_t  dividend,
  input  wire gat_pkg::sum_t  divisor,
  input  wire logic           stall,
  output logic                out_valid,
  output gat_pkg::alpha_t     quotient
);

  gat_pkg::rem_t   rem_q [gat_pkg::ALPHA_W-1];
  gat_pkg::sum_t   div_q [gat_pkg::ALPHA_W-1];
  gat_pkg::alpha_t quo_q [gat_pkg::ALPHA_W];
  logic            vld_q [gat_pkg::ALPHA_W];

  logic            out_vld_q;
  gat_pkg::alpha_t out_quo_q;

  // one restoring stage per quotient bit, msb first
  for (genvar i = 0; i < gat_pkg::ALPHA_W; i++) begin : g_stage
    gat_pkg::rem_t   rem_in;
    gat_pkg::rem_t   trial;
    gat_pkg::sum_t   div_in;
    gat_pkg::alpha_t quo_in;
    logic            vld_in;

    if (i == 0) begin : g_head
      // numerator is the dividend scaled by 2^WOF
      assign rem_in = gat_pkg::rem_t'(dividend) << gat_pkg::WOF;
      assign div_in = divisor;
      assign quo_in = '0;
      assign vld_in = issue;
    end else begin : g_body
      assign rem_in = rem_q[i-1];
      assign div_in = div_q[i-1];
      assign quo_in = quo_q[i-1];
      assign vld_in = vld_q[i-1];
    end

    assign trial = gat_pkg::rem_t'(div_in) << (gat_pkg::ALPHA_W - 1 - i);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q[i] <= 1'b0;
      end else if (!stall) begin
        vld_q[i] <= vld_in;
      end
    end

    always_ff @(posedge clk) begin
      if (!stall) begin
        if (rem_in >= trial) begin
          quo_q[i] <= quo_in | (gat_pkg::alpha_t'(1) << (gat_pkg::ALPHA_W - 1 - i));
        end else begin
          quo_q[i] <= quo_in;
        end
      end
    end

    // last stage only needs its quotient bit
    if (i < gat_pkg::ALPHA_W - 1) begin : g_pass
      always_ff @(posedge clk) begin
        if (!stall) begin
          div_q[i] <= div_in;
          rem_q[i] <= (rem_in >= trial) ? rem_in - trial : rem_in;
        end
      end
    end
  end

  // output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_vld_q <= 1'b0;
    end else if (!stall) begin
      out_vld_q <= vld_q[gat_pkg::ALPHA_W-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      out_quo_q <= quo_q[gat_pkg::ALPHA_W-1];
    end
  end

  assign out_valid = out_vld_q;
  assign quotient  = out_quo_q;

endmodule

`default_nettype wire

// File: design/gat_pkg.sv
`default_nettype none

package gat_pkg;

  localparam int COEF_W         = 4;
  localparam int EXP_W          = 16;
  localparam int NODE_W         = 8;
  localparam int NODE_ADDR_W    = 4;
  localparam int SUM_W          = EXP_W + NODE_W;
  localparam int WOF            = 15;
  localparam int ALPHA_W        = 16;
  localparam int DIVIDEND_DEPTH = 16;
  localparam int DIVISOR_DEPTH  = 4;
  localparam int DIV_LAT        = 17;
  // partial remainder must hold the divisor shifted by the top quotient bit
  localparam int REM_W          = SUM_W + ALPHA_W;

  typedef logic [COEF_W-1:0]       coef_t;
  typedef logic [EXP_W-1:0]        exp_t;
  typedef logic [SUM_W-1:0]        sum_t;
  typedef logic [NODE_W-1:0]       node_cnt_t;
  typedef logic [NODE_ADDR_W-1:0]  node_addr_t;
  typedef logic [ALPHA_W-1:0]      alpha_t;
  typedef logic [REM_W-1:0]        rem_t;
  // count in the upper bits, sum in the lower bits
  typedef logic [NODE_W+SUM_W-1:0] divisor_entry_t;

endpackage

`default_nettype wire

// File: design/softmax.sv
`timescale 1ns/100ps
`default_nettype none

module softmax (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                sm_valid,
  input  wire gat_pkg::coef_t      coef_dout,
  input  wire logic                coef_empty,
  output logic                     coef_rd,
  input  wire gat_pkg::node_cnt_t  num_node_dout,
  output gat_pkg::node_addr_t      num_node_addr,
  output gat_pkg::alpha_t          alpha_din,
  input  wire logic                alpha_full,
  output logic                     alpha_wr
);

  logic                    first;
  gat_pkg::exp_t           exp;
  gat_pkg::sum_t           sum_next;

  gat_pkg::exp_t           dividend_dout;
  logic                    dividend_full;
  logic                    dividend_empty;
  logic                    dividend_pop;

  gat_pkg::divisor_entry_t divisor_din;
  gat_pkg::divisor_entry_t divisor_head;
  logic                    divisor_full;
  logic                    divisor_empty;
  logic                    divisor_push;
  logic                    divisor_pop;

  logic                    div_issue;
  gat_pkg::sum_t           div_sum;
  logic                    out_valid;

  softmax_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .sm_valid       (sm_valid),
    .coef_empty     (coef_empty),
    .coef_rd        (coef_rd),
    .num_node_dout  (num_node_dout),
    .num_node_addr  (num_node_addr),
    .dividend_full  (dividend_full),
    .dividend_empty (dividend_empty),
    .divisor_full   (divisor_full),
    .divisor_empty  (divisor_empty),
    .divisor_head   (divisor_head),
    .alpha_full     (alpha_full),
    .first          (first),
    .divisor_push   (divisor_push),
    .dividend_pop   (dividend_pop),
    .divisor_pop    (divisor_pop),
    .div_issue      (div_issue),
    .div_sum        (div_sum)
  );

  exp_sum_unit u_exp_sum (
    .clk      (clk),
    .rst_n    (rst_n),
    .coef     (coef_dout),
    .accept   (coef_rd),
    .first    (first),
    .exp      (exp),
    .sum_next (sum_next)
  );

  sync_fifo #(
    .WIDTH (gat_pkg::EXP_W),
    .DEPTH (gat_pkg::DIVIDEND_DEPTH)
  ) u_dividend_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (exp),
    .wr    (coef_rd),
    .rd    (dividend_pop),
    .dout  (dividend_dout),
    .full  (dividend_full),
    .empty (dividend_empty)
  );

  // memory still shows this subgraph's count at its last node
  assign divisor_din = {num_node_dout, sum_next};

  sync_fifo #(
    .WIDTH ($bits(gat_pkg::divisor_entry_t)),
    .DEPTH (gat_pkg::DIVISOR_DEPTH)
  ) u_divisor_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (divisor_din),
    .wr    (divisor_push),
    .rd    (divisor_pop),
    .dout  (divisor_head),
    .full  (divisor_full),
    .empty (divisor_empty)
  );

  fxp_divider u_divider (
    .clk       (clk),
    .rst_n     (rst_n),
    .issue     (div_issue),
    .dividend  (dividend_dout),
    .divisor   (div_sum),
    .stall     (alpha_full),
    .out_valid (out_valid),
    .quotient  (alpha_din)
  );

  assign alpha_wr = out_valid && !alpha_full;

endmodule

`default_nettype wire

// File: design/softmax_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module softmax_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    sm_valid,
  input  wire logic                    coef_empty,
  output logic                         coef_rd,
  input  wire gat_pkg::node_cnt_t      num_node_dout,
  output gat_pkg::node_addr_t          num_node_addr,
  input  wire logic                    dividend_full,
  input  wire logic                    dividend_empty,
  input  wire logic                    divisor_full,
  input  wire logic                    divisor_empty,
  input  wire gat_pkg::divisor_entry_t divisor_head,
  input  wire logic                    alpha_full,
  output logic                         first,
  output logic                         divisor_push,
  output logic                         dividend_pop,
  output logic                         divisor_pop,
  output logic                         div_issue,
  output gat_pkg::sum_t                div_sum
);

  gat_pkg::node_cnt_t  node_cnt_q;
  gat_pkg::node_cnt_t  num_nodes_q;
  gat_pkg::node_cnt_t  cur_count;
  gat_pkg::node_addr_t addr_q;
  logic                last;

  gat_pkg::node_cnt_t  div_cnt_q;
  gat_pkg::node_cnt_t  div_nodes_q;
  gat_pkg::node_cnt_t  div_count;
  gat_pkg::sum_t       div_sum_q;
  logic                div_first;

  // intake side
  assign coef_rd   = sm_valid && !coef_empty && !dividend_full && !divisor_full;
  assign first     = (node_cnt_q == '0);
  assign cur_count = first ? num_node_dout : num_nodes_q;
  assign last      = (node_cnt_q == cur_count - 1'b1);

  // next address goes out early so the count is ready for the next first node
  assign num_node_addr = (coef_rd && last) ? addr_q + 1'b1 : addr_q;
  assign divisor_push  = coef_rd && last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_cnt_q  <= '0;
      num_nodes_q <= '0;
      addr_q      <= '0;
    end else if (coef_rd) begin
      if (first) begin
        num_nodes_q <= num_node_dout;
      end
      node_cnt_q <= last ? '0 : node_cnt_q + 1'b1;
      addr_q     <= num_node_addr;
    end
  end

  // divide side
  assign div_first    = (div_cnt_q == '0);
  assign div_issue    = !dividend_empty && (!div_first || !divisor_empty) && !alpha_full;
  assign dividend_pop = div_issue;
  assign divisor_pop  = div_issue && div_first;

  // head entry is used directly on the first node
  assign div_sum   = div_first ? divisor_head[gat_pkg::SUM_W-1:0] : div_sum_q;
  assign div_count = div_first ? divisor_head[gat_pkg::SUM_W +: gat_pkg::NODE_W] : div_nodes_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt_q   <= '0;
      div_nodes_q <= '0;
      div_sum_q   <= '0;
    end else if (div_issue) begin
      if (div_first) begin
        div_nodes_q <= div_count;
        div_sum_q   <= div_sum;
      end
      div_cnt_q <= (div_cnt_q == div_count - 1'b1) ? '0 : div_cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic [WIDTH-1:0] din,
  input  wire logic             wr,
  input  wire logic             rd,
  output logic      [WIDTH-1:0] dout,
  output logic                  full,
  output logic                  empty
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // show-ahead head entry
  assign dout  = mem[rd_ptr];
  assign full  = (count == DEPTH);
  assign empty = (count == '0);

endmodule

`default_nettype wire

// File: gat_softmax.f
design/gat_pkg.sv
design/sync_fifo.sv
design/exp_sum_unit.sv
design/fxp_divider.sv
design/softmax_ctrl.sv
design/softmax.sv
test/softmax_chk.sv
test/tb_softmax.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_softmax \
  -f gat_softmax.f -o sim_softmax

out=$(./obj_dir/sim_softmax)
echo "$out"

echo "$out" | grep -q "^Test passed$"

// File: test/softmax_chk.sv
`timescale 1ns/100ps
`default_nettype none

module softmax_chk (
  input wire logic                clk,
  input wire logic                rst_n,
  input wire logic                sm_valid,
  input wire logic                coef_empty,
  input wire logic                coef_rd,
  input wire gat_pkg::node_addr_t num_node_addr,
  input wire gat_pkg::alpha_t     alpha_din,
  input wire logic                alpha_full,
  input wire logic                alpha_wr
);

  // never write into a full alpha FIFO
  wr_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    alpha_wr |-> !alpha_full)
    else $error("alpha_wr high while alpha_full is high");

  rd_allowed: assert property (@(posedge clk) disable iff (!rst_n)
    coef_rd |-> (!coef_empty && sm_valid))
    else $error("coef_rd high with coef_empty high or sm_valid low");

  // control outputs known once out of reset
  ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({coef_rd, alpha_wr, num_node_addr}))
    else $error("unknown value on coef_rd, alpha_wr or num_node_addr");

  alpha_known: assert property (@(posedge clk) disable iff (!rst_n)
    alpha_wr |-> !$isunknown(alpha_din))
    else $error("unknown alpha_din on a write");

endmodule

`default_nettype wire

// File: test/tb_softmax.sv
`timescale 1ns/100ps
`default_nettype none

module tb_softmax;

  logic                clk;
  logic                rst_n;
  logic                sm_valid;
  gat_pkg::coef_t      coef_dout;
  logic                coef_empty;
  logic                coef_rd;
  gat_pkg::node_cnt_t  num_node_dout;
  gat_pkg::node_addr_t num_node_addr;
  gat_pkg::alpha_t     alpha_din;
  logic                alpha_full;
  logic                alpha_wr;

  gat_pkg::coef_t     coef_q[$];
  gat_pkg::coef_t     sub_q[$];
  gat_pkg::coef_t     saved_coefs[$];
  gat_pkg::alpha_t    got_q[$];
  int                 exp_q[$];
  gat_pkg::node_cnt_t count_mem [2**gat_pkg::NODE_ADDR_W];
  logic               coef_hold;
  logic [31:0]        lfsr;
  int                 errors;
  int                 test_errors;
  int                 tests_run;

  softmax UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .sm_valid      (sm_valid),
    .coef_dout     (coef_dout),
    .coef_empty    (coef_empty),
    .coef_rd       (coef_rd),
    .num_node_dout (num_node_dout),
    .num_node_addr (num_node_addr),
    .alpha_din     (alpha_din),
    .alpha_full    (alpha_full),
    .alpha_wr      (alpha_wr)
  );

  bind softmax softmax_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .sm_valid      (sm_valid),
    .coef_empty    (coef_empty),
    .coef_rd       (coef_rd),
    .num_node_addr (num_node_addr),
    .alpha_din     (alpha_din),
    .alpha_full    (alpha_full),
    .alpha_wr      (alpha_wr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // show-ahead coefficient FIFO, coef_hold makes it look empty
  always @(posedge clk) begin
    if (coef_rd) begin
      void'(coef_q.pop_front());
    end
    coef_empty <= coef_hold || (coef_q.size() == 0);
    coef_dout  <= (coef_q.size() != 0) ? coef_q[0] : '0;
  end

  // count memory with registered read
  always @(posedge clk) begin
    num_node_dout <= count_mem[num_node_addr];
  end

  // alpha sink
  always @(posedge clk) begin
    if (rst_n && alpha_wr) begin
      assert (!alpha_full) else begin
        $display("alpha written while alpha_full was high");
        test_errors++;
      end
      got_q.push_back(alpha_din);
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s, %0d failed checks", name, (test_errors == 0) ? "ok" : "errors",
             test_errors);
    errors += test_errors;
    tests_run++;
  endtask

  task automatic apply_reset();
    test_errors = 0;
    rst_n      <= 1'b0;
    sm_valid   <= 1'b0;
    coef_hold  <= 1'b1;
    alpha_full <= 1'b0;
    coef_q.delete();
    got_q.delete();
    exp_q.delete();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
  endtask

  // alpha = floor(2^c * 2^WOF / sum of 2^c over the subgraph)
  task automatic queue_subgraph(input int addr);
    longint sum;
    sum = 0;
    foreach (sub_q[i]) begin
      sum += longint'(1) << sub_q[i];
    end
    count_mem[addr] = gat_pkg::node_cnt_t'(sub_q.size());
    foreach (sub_q[i]) begin
      exp_q.push_back(int'((longint'(1) << (sub_q[i] + gat_pkg::WOF)) / sum));
      coef_q.push_back(sub_q[i]);
    end
    sub_q.delete();
  endtask

  // subgraphs of 1 to 8 nodes at addresses 0 to 7
  task automatic load_ramp(input bit replay);
    int             idx;
    gat_pkg::coef_t c;
    idx = 0;
    if (!replay) begin
      saved_coefs.delete();
    end
    for (int k = 1; k <= 8; k++) begin
      for (int j = 0; j < k; j++) begin
        c = replay ? saved_coefs[idx] : gat_pkg::coef_t'(rand_bits(gat_pkg::COEF_W));
        if (!replay) begin
          saved_coefs.push_back(c);
        end
        sub_q.push_back(c);
        idx++;
      end
      queue_subgraph(k - 1);
    end
  endtask

  task automatic run_and_check(input string name, input bit gaps, input bit backpressure);
    int cycles;
    int bp_left;
    cycles  = 0;
    bp_left = 0;
    sm_valid  <= 1'b1;
    coef_hold <= 1'b0;
    while (got_q.size() < exp_q.size() && cycles < 5000) begin
      @(posedge clk);
      cycles++;
      if (gaps) begin
        sm_valid  <= (rand_bits(2) != 0);
        coef_hold <= (rand_bits(2) == 0);
      end
      if (backpressure) begin
        if (bp_left == 0) begin
          alpha_full <= (rand_bits(1) != 0);
          bp_left = 1 + int'(rand_bits(4));
        end else begin
          bp_left--;
        end
      end
    end
    if (got_q.size() < exp_q.size()) begin
      $display("%s: timed out waiting for alpha writes, got %0d of %0d", name,
               got_q.size(), exp_q.size());
      test_errors++;
    end
    sm_valid   <= 1'b0;
    coef_hold  <= 1'b1;
    alpha_full <= 1'b0;
    // room for any extra write to show up
    repeat (2 * gat_pkg::DIV_LAT) @(posedge clk);
    check_value({name, " alpha count"}, exp_q.size(), got_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check_value($sformatf("%s alpha %0d", name, i), exp_q[i], got_q[i]);
    end
    finish_test(name);
  endtask

  task automatic test_reset();
    test_errors = 0;
    rst_n      <= 1'b0;
    sm_valid   <= 1'b0;
    coef_hold  <= 1'b1;
    alpha_full <= 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_value("reset coef_rd", 0, coef_rd);
      check_value("reset alpha_wr", 0, alpha_wr);
      check_value("reset num_node_addr", 0, num_node_addr);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("post reset coef_rd", 0, coef_rd);
    check_value("post reset alpha_wr", 0, alpha_wr);
    check_value("post reset num_node_addr", 0, num_node_addr);
    @(posedge clk);
    finish_test("reset");
  endtask

  task automatic test_single();
    apply_reset();
    sub_q.push_back(4'd0);
    queue_subgraph(0);
    sub_q.push_back(4'd15);
    queue_subgraph(1);
    sub_q.push_back(gat_pkg::coef_t'(rand_bits(gat_pkg::COEF_W)));
    queue_subgraph(2);
    run_and_check("single", 1'b0, 1'b0);
  endtask

  task automatic test_equal();
    apply_reset();
    repeat (3) sub_q.push_back(4'd9);
    queue_subgraph(0);
    repeat (7) sub_q.push_back(4'd2);
    queue_subgraph(1);
    run_and_check("equal", 1'b0, 1'b0);
  endtask

  initial begin
    rst_n         = 1'b0;
    sm_valid      = 1'b0;
    coef_hold     = 1'b1;
    alpha_full    = 1'b0;
    coef_empty    = 1'b1;
    coef_dout     = '0;
    num_node_dout = '0;
    lfsr          = 32'hfb11_8805;
    errors        = 0;
    test_errors   = 0;
    tests_run     = 0;
    foreach (count_mem[i]) begin
      count_mem[i] = '0;
    end

    test_reset();
    test_single();
    test_equal();
    apply_reset();
    load_ramp(1'b0);
    run_and_check("ramp", 1'b0, 1'b0);
    apply_reset();
    load_ramp(1'b1);
    run_and_check("gaps", 1'b1, 1'b0);
    apply_reset();
    load_ramp(1'b0);
    run_and_check("backpressure", 1'b0, 1'b1);

    $display("tests run: %0d, failed checks: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
